//--- common/uart_pkg.sv
/* Shared constants for the Wishbone UART: frame format, register map and reset values.
   Modules import it in their bodies and use scoped names in their port lists */
package uart_pkg;

    //////////////////////////////
    // Frame format
    //////////////////////////////

    // 8N1 frames, LSB first
    localparam int UART_DATA_BITS = 8;
    // Counter width for the data bit index
    localparam int UART_CNT_WIDTH = $clog2(UART_DATA_BITS);
    // Index of the last data bit in a frame
    localparam logic [UART_CNT_WIDTH-1:0] UART_LAST_BIT = UART_CNT_WIDTH'(UART_DATA_BITS - 1);

    // State encoding shared by the transmit and receive FSMs
    localparam int UART_ST_WIDTH = 2;
    localparam logic [UART_ST_WIDTH-1:0] UART_ST_IDLE  = 2'd0;
    localparam logic [UART_ST_WIDTH-1:0] UART_ST_START = 2'd1;
    localparam logic [UART_ST_WIDTH-1:0] UART_ST_DATA  = 2'd2;
    localparam logic [UART_ST_WIDTH-1:0] UART_ST_STOP  = 2'd3;

    //////////////////////////////
    // Divider
    //////////////////////////////

    localparam int UART_DIV_WIDTH = 32;
    // Bit period in cycles is divider + offset
    localparam logic [UART_DIV_WIDTH-1:0] UART_DIV_OFFSET  = 32'd2;
    // Gives a 3-cycle bit period out of reset
    localparam logic [UART_DIV_WIDTH-1:0] UART_DEFAULT_DIV = 32'd1;

    //////////////////////////////
    // Register map
    //////////////////////////////

    // Address bit 2 picks the word
    localparam logic UART_ADR_SD = 1'b0;
    localparam logic UART_ADR_CD = 1'b1;
    // Status byte bits
    localparam int UART_STAT_RX_VALID = 0;
    localparam int UART_STAT_TX_BUSY  = 1;
    // Data read value with no byte waiting
    localparam logic [UART_DATA_BITS-1:0] UART_RX_EMPTY = 8'hFF;

endpackage

//--- uart/uart_baud_timer.sv
/* Bit-period timer for one UART direction; ticks once per divider+2 cycles.
   A restart with half_i set makes the first tick come after half a period */
`timescale 1ns/100ps

module uart_baud_timer (
    input  logic                              wb_clk_i,
    input  logic                              wb_rst_i,
    input  logic [uart_pkg::UART_DIV_WIDTH-1:0] div_i,
    input  logic                              restart_i,
    input  logic                              half_i,
    output logic                              bit_tick_o
);
    import uart_pkg::*;

    // Remaining cycles in the current period, zero on the last one
    logic [UART_DIV_WIDTH-1:0] cnt_q;
    // Full and half bit period in cycles
    logic [UART_DIV_WIDTH-1:0] period;
    logic [UART_DIV_WIDTH-1:0] half_period;

    assign period      = div_i + UART_DIV_OFFSET;
    // Rounds down, smallest period 2 gives 1
    assign half_period = period >> 1;

    // Tick on the last cycle of each period
    assign bit_tick_o = (cnt_q == '0);

    //////////////////////////////
    // Down-counter
    //////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            cnt_q <= '0;
        end else if (restart_i) begin
            // Restart wins over a tick in the same cycle
            if (half_i) begin
                cnt_q <= half_period - 1'b1;
            end else begin
                cnt_q <= period - 1'b1;
            end
        end else if (bit_tick_o) begin
            // Reload so the next bit follows with no gap
            cnt_q <= period - 1'b1;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

endmodule

//--- uart/uart_tx_fsm.sv
/* Transmit FSM; sends one 8N1 frame per start pulse, LSB first.
   Drives its own baud timer through timer_restart_o and steps on each bit tick */
`timescale 1ns/100ps

module uart_tx_fsm (
    input  logic                              wb_clk_i,
    input  logic                              wb_rst_i,
    input  logic                              start_i,
    input  logic [uart_pkg::UART_DATA_BITS-1:0] byte_i,
    input  logic                              bit_tick_i,
    output logic                              timer_restart_o,
    output logic                              busy_o,
    output logic                              tx_o
);
    import uart_pkg::*;

    logic [UART_ST_WIDTH-1:0]  state_q;
    // Bits still to send, shifted right
    logic [UART_DATA_BITS-1:0] shift_q;
    // Data bit index
    logic [UART_CNT_WIDTH-1:0] bit_cnt_q;
    // Line level, idle high
    logic                      tx_q;

    // Timer starts together with the start bit
    assign timer_restart_o = (state_q == UART_ST_IDLE) && start_i;
    // High from the start bit through the stop bit
    assign busy_o          = (state_q != UART_ST_IDLE);
    assign tx_o            = tx_q;

    //////////////////////////////
    // Frame sequencing
    //////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q   <= UART_ST_IDLE;
            bit_cnt_q <= '0;
            tx_q      <= 1'b1;
        end else begin
            case (state_q)
                UART_ST_IDLE: begin
                    if (start_i) begin
                        // Start bit goes out right away
                        state_q <= UART_ST_START;
                        tx_q    <= 1'b0;
                    end
                end
                UART_ST_START: begin
                    if (bit_tick_i) begin
                        state_q   <= UART_ST_DATA;
                        bit_cnt_q <= '0;
                        tx_q      <= shift_q[0];
                    end
                end
                UART_ST_DATA: begin
                    if (bit_tick_i) begin
                        if (bit_cnt_q == UART_LAST_BIT) begin
                            // Last data bit done, drive the stop bit
                            state_q <= UART_ST_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            tx_q      <= shift_q[1];
                        end
                    end
                end
                default: begin
                    // Stop bit, line already high
                    if (bit_tick_i) begin
                        state_q <= UART_ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Shift register, loaded on start, advanced as each data bit begins
    always_ff @(posedge wb_clk_i) begin
        if ((state_q == UART_ST_IDLE) && start_i) begin
            shift_q <= byte_i;
        end else if ((state_q == UART_ST_DATA) && bit_tick_i) begin
            shift_q <= {1'b0, shift_q[UART_DATA_BITS-1:1]};
        end
    end

endmodule

//--- uart/uart_rx_fsm.sv
/* Receive FSM; finds a start bit on rx_i, samples each bit at mid-period and
   pulses done_o with the assembled byte when the stop bit is high */
`timescale 1ns/100ps

module uart_rx_fsm (
    input  logic                              wb_clk_i,
    input  logic                              wb_rst_i,
    input  logic                              rx_i,
    input  logic                              bit_tick_i,
    output logic                              timer_restart_o,
    output logic                              timer_half_o,
    output logic                              done_o,
    output logic [uart_pkg::UART_DATA_BITS-1:0] byte_o
);
    import uart_pkg::*;

    //////////////////////////////
    // Input sync and edge detect
    //////////////////////////////

    // Two-flop synchronizer plus one delayed copy for the edge
    logic rx_meta_q;
    logic rx_sync_q;
    logic rx_prev_q;
    logic rx_fall;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            // Idle line is high, so no false edge out of reset
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    assign rx_fall = rx_prev_q && !rx_sync_q;

    //////////////////////////////
    // Frame state
    //////////////////////////////

    logic [UART_ST_WIDTH-1:0]  state_q;
    logic [UART_DATA_BITS-1:0] shift_q;
    logic [UART_CNT_WIDTH-1:0] bit_cnt_q;
    logic                      done_q;

    // Half-period restart on the falling edge puts later ticks at mid-bit
    assign timer_restart_o = (state_q == UART_ST_IDLE) && rx_fall;
    assign timer_half_o    = (state_q == UART_ST_IDLE);
    assign done_o          = done_q;
    // Byte is stable from the done pulse until the next frame shifts in
    assign byte_o          = shift_q;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q   <= UART_ST_IDLE;
            bit_cnt_q <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                UART_ST_IDLE: begin
                    if (rx_fall) begin
                        state_q <= UART_ST_START;
                    end
                end
                UART_ST_START: begin
                    if (bit_tick_i) begin
                        // Glitch if the line is high again by mid-bit
                        if (!rx_sync_q) begin
                            state_q   <= UART_ST_DATA;
                            bit_cnt_q <= '0;
                        end else begin
                            state_q <= UART_ST_IDLE;
                        end
                    end
                end
                UART_ST_DATA: begin
                    if (bit_tick_i) begin
                        if (bit_cnt_q == UART_LAST_BIT) begin
                            state_q <= UART_ST_STOP;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bit_tick_i) begin
                        // Frame with a low stop bit is dropped
                        done_q  <= rx_sync_q;
                        state_q <= UART_ST_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge wb_clk_i) begin
        if ((state_q == UART_ST_DATA) && bit_tick_i) begin
            shift_q <= {rx_sync_q, shift_q[UART_DATA_BITS-1:1]};
        end
    end

endmodule

//--- uart/uart_wb_regs.sv
/* Wishbone slave for the UART: data/status word at address 0, divider at address 4.
   Registered single-cycle ack, byte-selected writes, receive buffer with read-clear */
`timescale 1ns/100ps

module uart_wb_regs (
    input  logic                              wb_clk_i,
    input  logic                              wb_rst_i,
    input  logic [2:2]                        wb_adr_i,
    input  logic [31:0]                       wb_dat_i,
    output logic [31:0]                       wb_dat_o,
    input  logic                              wb_we_i,
    input  logic [3:0]                        wb_sel_i,
    input  logic                              wb_stb_i,
    output logic                              wb_ack_o,
    input  logic                              tx_busy_i,
    input  logic                              rx_done_i,
    input  logic [uart_pkg::UART_DATA_BITS-1:0] rx_byte_i,
    output logic                              tx_start_o,
    output logic [uart_pkg::UART_DATA_BITS-1:0] tx_byte_o,
    output logic [uart_pkg::UART_DIV_WIDTH-1:0] div_o
);
    import uart_pkg::*;

    //////////////////////////////
    // Decode
    //////////////////////////////

    logic                      sel_sd;
    logic                      sel_cd;
    // Strobe sampled once per access, the ack cycle is not a new one
    logic                      access;
    logic [3:0]                div_we;
    logic                      data_we;
    logic                      data_re;

    assign sel_sd  = (wb_adr_i == UART_ADR_SD);
    assign sel_cd  = (wb_adr_i == UART_ADR_CD);
    assign access  = wb_stb_i && !wb_ack_o;
    assign div_we  = (sel_cd && access && wb_we_i) ? wb_sel_i : 4'b0000;
    assign data_we = sel_sd && access && wb_we_i && wb_sel_i[0];
    assign data_re = sel_sd && access && !wb_we_i && wb_sel_i[0];

    // Ack one cycle after the strobe and never twice in a row
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_stb_i && !wb_ack_o;
        end
    end

    //////////////////////////////
    // Divider
    //////////////////////////////

    logic [UART_DIV_WIDTH-1:0] div_q;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            div_q <= UART_DEFAULT_DIV;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (div_we[i]) begin
                    div_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
                end
            end
        end
    end

    assign div_o = div_q;

    //////////////////////////////
    // Transmit request
    //////////////////////////////

    // Write while busy is dropped, software polls tx_busy first
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            tx_start_o <= 1'b0;
        end else begin
            tx_start_o <= data_we && !tx_busy_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (data_we && !tx_busy_i) begin
            tx_byte_o <= wb_dat_i[UART_DATA_BITS-1:0];
        end
    end

    //////////////////////////////
    // Receive buffer
    //////////////////////////////

    logic [UART_DATA_BITS-1:0] rx_buf_q;
    logic                      rx_valid_q;
    // Read seen in the ack cycle, clears on the edge after
    logic                      rd_clr_q;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            rd_clr_q   <= 1'b0;
            rx_valid_q <= 1'b0;
        end else begin
            rd_clr_q <= data_re;
            if (rd_clr_q) begin
                rx_valid_q <= 1'b0;
            end
            // A new byte wins over the clear and overwrites an unread one
            if (rx_done_i) begin
                rx_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rx_done_i) begin
            rx_buf_q <= rx_byte_i;
        end
    end

    //////////////////////////////
    // Read mux
    //////////////////////////////

    logic [7:0]                status;
    logic [UART_DATA_BITS-1:0] rd_data;

    always_comb begin
        status                     = 8'h00;
        status[UART_STAT_RX_VALID] = rx_valid_q;
        status[UART_STAT_TX_BUSY]  = tx_busy_i;
    end

    assign rd_data  = rx_valid_q ? rx_buf_q : UART_RX_EMPTY;
    // Data in byte 0, status in byte 1
    assign wb_dat_o = sel_cd ? div_q : {16'h0000, status, rd_data};

endmodule

//--- src/uart_wb_top.sv
/* Top level of the Wishbone UART; wires the register block to the transmit and
   receive FSMs and their baud timers */
`timescale 1ns/100ps

module uart_wb_top (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic [2:2]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    input  logic        wb_we_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_stb_i,
    output logic        wb_ack_o,
    input  logic        rx_i,
    output logic        tx_o
);
    import uart_pkg::*;

    // Register block to transmitter
    logic                      tx_start;
    logic [UART_DATA_BITS-1:0] tx_byte;
    logic                      tx_busy;
    // Receiver to register block
    logic                      rx_done;
    logic [UART_DATA_BITS-1:0] rx_byte;
    // Divider shared by both timers
    logic [UART_DIV_WIDTH-1:0] div;
    // Timer handshakes
    logic                      tx_restart;
    logic                      tx_tick;
    logic                      rx_restart;
    logic                      rx_half;
    logic                      rx_tick;

    uart_wb_regs regs (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_we_i    (wb_we_i),
        .wb_sel_i   (wb_sel_i),
        .wb_stb_i   (wb_stb_i),
        .wb_ack_o   (wb_ack_o),
        .tx_busy_i  (tx_busy),
        .rx_done_i  (rx_done),
        .rx_byte_i  (rx_byte),
        .tx_start_o (tx_start),
        .tx_byte_o  (tx_byte),
        .div_o      (div)
    );

    //////////////////////////////
    // Transmit path
    //////////////////////////////

    // Transmitter always restarts at a full period
    uart_baud_timer tx_timer (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .div_i      (div),
        .restart_i  (tx_restart),
        .half_i     (1'b0),
        .bit_tick_o (tx_tick)
    );

    uart_tx_fsm tx_fsm (
        .wb_clk_i        (wb_clk_i),
        .wb_rst_i        (wb_rst_i),
        .start_i         (tx_start),
        .byte_i          (tx_byte),
        .bit_tick_i      (tx_tick),
        .timer_restart_o (tx_restart),
        .busy_o          (tx_busy),
        .tx_o            (tx_o)
    );

    //////////////////////////////
    // Receive path
    //////////////////////////////

    uart_baud_timer rx_timer (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .div_i      (div),
        .restart_i  (rx_restart),
        .half_i     (rx_half),
        .bit_tick_o (rx_tick)
    );

    uart_rx_fsm rx_fsm (
        .wb_clk_i        (wb_clk_i),
        .wb_rst_i        (wb_rst_i),
        .rx_i            (rx_i),
        .bit_tick_i      (rx_tick),
        .timer_restart_o (rx_restart),
        .timer_half_o    (rx_half),
        .done_o          (rx_done),
        .byte_o          (rx_byte)
    );

endmodule

//--- tests/tb_uart_wb_tasks.svh
/* Bus access, serial frame monitor and wait helpers; included inside the testbench top */
`ifndef TB_UART_WB_TASKS_SVH
`define TB_UART_WB_TASKS_SVH

// One Wishbone access with ack sampled on the falling edge
// Strobe is dropped again on the next rising edge
task automatic run_access(input logic adr, input logic we, input logic [31:0] wdat,
                          input logic [3:0] sel, output logic [31:0] rdat);
    int waited;
    waited = 0;
    @(posedge wb_clk_i);
    wb_stb_i <= 1'b1;
    wb_adr_i <= adr;
    wb_we_i  <= we;
    wb_dat_i <= wdat;
    wb_sel_i <= sel;
    @(negedge wb_clk_i);
    while (!wb_ack_o) begin
        if (waited == ACK_TIMEOUT) begin
            stop_on_error("ERROR: the UART never acknowledged a bus strobe");
        end else begin
            waited++;
            @(negedge wb_clk_i);
        end
    end
    // Data is still valid in the ack cycle
    rdat = wb_dat_o;
    // First falling edge is still in the strobe cycle, ack belongs to the next one
    assert (waited == 1) else report_mismatch("ack not exactly one cycle after strobe");
    @(posedge wb_clk_i);
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
endtask

task automatic write_reg(input logic adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused;
    run_access(adr, 1'b1, dat, sel, unused);
endtask

task automatic read_reg(input logic adr, output logic [31:0] dat);
    run_access(adr, 1'b0, 32'h0, 4'hF, dat);
endtask

// Decodes one frame from tx_o where every bit must hold for exactly one period
task automatic capture_frame(input int period, output logic [7:0] data);
    int   waited;
    logic level;
    waited = 0;
    @(negedge wb_clk_i);
    while (tx_line !== 1'b0) begin
        if (waited == period + 4) begin
            stop_on_error("ERROR: no start bit appeared on tx_o after a data write");
        end else begin
            waited++;
            @(negedge wb_clk_i);
        end
    end
    for (int k = 0; k < FRAME_BITS; k++) begin
        for (int c = 0; c < period; c++) begin
            if (k != 0 || c != 0) begin
                @(negedge wb_clk_i);
            end
            if (c == 0) begin
                level = tx_line;
            end else begin
                assert (tx_line === level)
                    else report_mismatch(
                        $sformatf("frame bit %0d changed after %0d cycles", k, c));
            end
        end
        if (k == FRAME_BITS - 1) begin
            assert (level === 1'b1) else report_mismatch("stop bit is low");
        end else if (k != 0) begin
            // LSB first
            data[k-1] = level;
        end
    end
endtask

// Line must stay high, so no extra frame starts
task automatic expect_line_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
        @(negedge wb_clk_i);
        assert (tx_line === 1'b1) else report_mismatch("unexpected frame on tx_o");
    end
endtask

task automatic wait_rx_frames(input int target, input int limit);
    int waited;
    waited = 0;
    while (rx_frames < target) begin
        if (waited == limit) begin
            stop_on_error("ERROR: the receiver did not finish a looped-back frame in time");
        end else begin
            waited++;
            @(negedge wb_clk_i);
        end
    end
    assert (rx_frames == target) else report_mismatch("receiver accepted an extra frame");
endtask

`endif

//--- tests/tb_uart_wb.sv
/* Testbench for the Wishbone UART; tx_o loops back to rx_i. Covers reset state, ack,
   byte-selected divider writes, transmit frames, receive with read-clear and overrun */
`timescale 1ns/100ps

module tb_uart_wb;
    import uart_pkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int ACK_TIMEOUT   = 8;
    localparam int BYTES_PER_DIV = 3;
    // 1 start + 8 data + 1 stop
    localparam int FRAME_BITS    = UART_DATA_BITS + 2;

    logic        wb_clk_i = 1'b0;
    logic        wb_rst_i;
    logic [2:2]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_we_i;
    logic [3:0]  wb_sel_i;
    logic        wb_stb_i;
    logic        wb_ack_o;
    // Serial loopback
    wire         tx_line;

    integer      seed = 73;
    // Frames the receiver accepted so far
    int          rx_frames;

    uart_wb_top UUT (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_we_i  (wb_we_i),
        .wb_sel_i (wb_sel_i),
        .wb_stb_i (wb_stb_i),
        .wb_ack_o (wb_ack_o),
        .rx_i     (tx_line),
        .tx_o     (tx_line)
    );

    always #10 wb_clk_i = ~wb_clk_i;

    always @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            rx_frames <= 0;
        end else if (UUT.rx_done) begin
            rx_frames <= rx_frames + 1;
        end
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        stop_on_error($sformatf("MISMATCH at %0t: %s", $time, msg));
    endtask

    `include "tb_uart_wb_tasks.svh"

    //////////////////////////////
    // Ack protocol
    //////////////////////////////

    ack_follows_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        (wb_stb_i && !wb_ack_o) |=> wb_ack_o)
        else report_mismatch("strobe not acknowledged on the next cycle");
    ack_single_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_ack_o |=> !wb_ack_o)
        else report_mismatch("ack high two cycles in a row");
    ack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        !wb_stb_i |=> !wb_ack_o)
        else report_mismatch("ack without a strobe");

    // Expected read word at address 0, data in byte 0 and status in byte 1
    function automatic logic [31:0] status_word(input logic valid, input logic busy,
                                                input logic [7:0] data);
        logic [7:0] stat;
        stat = 8'h00;
        stat[UART_STAT_RX_VALID] = valid;
        stat[UART_STAT_TX_BUSY]  = busy;
        return {16'h0000, stat, data};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] sel);
        logic [31:0] merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        assert (got === exp)
            else report_mismatch($sformatf("%s read %h expected %h", what, got, exp));
    endtask

    //////////////////////////////
    // Stimulus sequence
    //////////////////////////////

    initial begin : main
        logic [31:0] rd;
        logic [31:0] rnd;
        logic [31:0] div_val;
        logic [7:0]  tx_byte;
        logic [7:0]  tx_byte2;
        logic [7:0]  got;
        int          period;
        int          frames;

        wb_rst_i = 1'b1;
        wb_adr_i = UART_ADR_SD;
        wb_dat_i = 32'h0;
        wb_we_i  = 1'b0;
        wb_sel_i = 4'h0;
        wb_stb_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;

        // Reset state
        @(negedge wb_clk_i);
        assert (tx_line === 1'b1) else report_mismatch("tx_o not idle high after reset");
        read_reg(UART_ADR_CD, rd);
        check_word(rd, UART_DEFAULT_DIV, "divider after reset");
        read_reg(UART_ADR_SD, rd);
        check_word(rd, status_word(1'b0, 1'b0, UART_RX_EMPTY), "data word after reset");

        // Divider write with random byte selects
        rnd = $random(seed);
        div_val = $random(seed);
        write_reg(UART_ADR_CD, rnd, div_val[3:0]);
        read_reg(UART_ADR_CD, rd);
        check_word(rd, merge_bytes(UART_DEFAULT_DIV, rnd, div_val[3:0]), "divider merge");

        frames = 0;
        for (int d = 0; d < 2; d++) begin
            div_val = (d == 0) ? 32'd1 : 32'd6;
            period  = div_val + UART_DIV_OFFSET;
            write_reg(UART_ADR_CD, div_val, 4'hF);
            read_reg(UART_ADR_CD, rd);
            check_word(rd, div_val, "divider setting");
            for (int n = 0; n < BYTES_PER_DIV; n++) begin
                rnd = $random(seed);
                tx_byte = rnd[7:0];
                write_reg(UART_ADR_SD, {24'h0, tx_byte}, 4'hF);
                // Monitor runs while the bus polls and tries a write during busy
                fork
                    capture_frame(period, got);
                    begin
                        read_reg(UART_ADR_SD, rd);
                        check_word(rd, status_word(1'b0, 1'b1, UART_RX_EMPTY), "busy status");
                        write_reg(UART_ADR_SD, {24'h0, ~tx_byte}, 4'hF);
                    end
                join
                assert (got === tx_byte)
                    else report_mismatch($sformatf("frame held %h expected %h", got, tx_byte));
                expect_line_idle(FRAME_BITS * period + period);
                frames++;
                wait_rx_frames(frames, 4 * period + 16);
                read_reg(UART_ADR_SD, rd);
                check_word(rd, status_word(1'b1, 1'b0, tx_byte), "received byte");
                read_reg(UART_ADR_SD, rd);
                check_word(rd, status_word(1'b0, 1'b0, UART_RX_EMPTY), "data after read-clear");
            end
        end

        // Overrun, second byte replaces the unread first one
        rnd = $random(seed);
        tx_byte  = rnd[7:0];
        tx_byte2 = rnd[15:8];
        write_reg(UART_ADR_SD, {24'h0, tx_byte}, 4'hF);
        capture_frame(period, got);
        assert (got === tx_byte) else report_mismatch("first overrun frame wrong");
        write_reg(UART_ADR_SD, {24'h0, tx_byte2}, 4'hF);
        capture_frame(period, got);
        assert (got === tx_byte2) else report_mismatch("second overrun frame wrong");
        frames += 2;
        wait_rx_frames(frames, 4 * period + 16);
        read_reg(UART_ADR_SD, rd);
        check_word(rd, status_word(1'b1, 1'b0, tx_byte2), "byte after overrun");
        read_reg(UART_ADR_SD, rd);
        check_word(rd, status_word(1'b0, 1'b0, UART_RX_EMPTY), "data after overrun read");

        $display("all tests passed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+tests
common/uart_pkg.sv
uart/uart_baud_timer.sv
uart/uart_tx_fsm.sv
uart/uart_rx_fsm.sv
uart/uart_wb_regs.sv
src/uart_wb_top.sv
tests/tb_uart_wb.sv
